// ==== rsc2_dec_pkg.sv ====
// duobinary decoder LLR package

package rsc2_dec_pkg;

  // ------------------------------
  // widths and sizes
  // ------------------------------

  localparam int LLR_W        = 5;          // symbol LLRs
  localparam int SM_W         = 10;         // alpha / beta
  localparam int BM_W         = SM_W + 1;   // branch metric and max tree
  localparam int EXTR_W       = 6;          // saturated extrinsic
  localparam int N_STATES     = 16;
  localparam int N_HYP        = 4;          // duobit hypotheses
  localparam int LAPO_LATENCY = 6;          // sum + 4 max layers + offset

  // ------------------------------
  // metric types
  // ------------------------------

  typedef logic signed [LLR_W-1:0]  llr_t;
  typedef logic signed [SM_W-1:0]   metric_t;
  typedef logic signed [BM_W-1:0]   branch_t;
  typedef logic signed [EXTR_W-1:0] extr_val_t;

  typedef llr_t    [1:3]                      hyp_llr_t;   // per hyp, 00 implied zero
  typedef llr_t    [1:0]                      llr_pair_t;  // two parity LLRs
  typedef metric_t [N_STATES-1:0]             state_t;
  typedef branch_t [N_STATES-1:0][N_HYP-1:0]  gamma_t;     // gamma_e + alpha
  typedef branch_t [N_STATES-1:0][N_HYP-1:0]  bm_t;        // alpha + gamma_e + beta
  typedef branch_t [1:3]                      lapo_t;
  typedef extr_val_t [1:3]                    extr_t;

  // duobit hypothesis {a, b}
  typedef enum logic [1:0] {
    HYP_00,
    HYP_01,
    HYP_10,
    HYP_11
  } hyp_e;

  // ------------------------------
  // trellis
  // ------------------------------

  typedef logic [N_STATES-1:0][N_HYP-1:0][3:0] next_tab_t;
  typedef logic [N_STATES-1:0][N_HYP-1:0][1:0] par_tab_t;

  // one encoder step, returns {par[1:0], next[3:0]}
  // r[0] is the D cell ... r[3] the D^4 cell
  function automatic logic [5:0] trel_step(int s, int h);
    logic [3:0] r;
    logic [3:0] nxt;
    logic [1:0] par;
    logic       a;
    logic       b;
    logic       w;
    r      = 4'(s);
    a      = h[1];
    b      = h[0];
    w      = a ^ b ^ r[2] ^ r[3];           // feedback 1+D^3+D^4, both bits at tap 0
    nxt    = {r[2], r[1], r[0] ^ b, w};     // b again at tap 1
    par[0] = w ^ r[0] ^ r[3];               // 1+D+D^4
    par[1] = w ^ r[1] ^ r[3];               // 1+D^2+D^4
    return {par, nxt};
  endfunction

  function automatic next_tab_t gen_next_states();
    next_tab_t tab;
    logic [5:0] step;
    for (int s = 0; s < N_STATES; s++) begin
      for (int h = 0; h < N_HYP; h++) begin
        step      = trel_step(s, h);
        tab[s][h] = step[3:0];
      end
    end
    return tab;
  endfunction

  function automatic par_tab_t gen_parity();
    par_tab_t tab;
    logic [5:0] step;
    for (int s = 0; s < N_STATES; s++) begin
      for (int h = 0; h < N_HYP; h++) begin
        step      = trel_step(s, h);
        tab[s][h] = step[5:4];
      end
    end
    return tab;
  endfunction

  localparam next_tab_t trel_next_states = gen_next_states();
  localparam par_tab_t  trel_parity      = gen_parity();

  // ------------------------------
  // arithmetic helpers
  // ------------------------------

  localparam branch_t EXTR_MAX = branch_t'((1 << (EXTR_W - 1)) - 1);
  localparam branch_t EXTR_MIN = -branch_t'(1 << (EXTR_W - 1));

  function automatic branch_t bm_max(branch_t a, branch_t b);
    return (a > b) ? a : b;   // plain max-log, no correction
  endfunction

  function automatic extr_val_t sat_extr(branch_t v);
    if (v > EXTR_MAX)
      return extr_val_t'(EXTR_MAX);
    if (v < EXTR_MIN)
      return extr_val_t'(EXTR_MIN);
    return extr_val_t'(v);
  endfunction

endpackage

// ==== rsc2_dec_gamma.sv ====
// branch metric unit

module rsc2_dec_gamma
  import rsc2_dec_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  //
  input  logic      ival,
  input  hyp_llr_t  lsys,
  input  hyp_llr_t  lapri,
  input  llr_pair_t lpar,
  input  state_t    alpha,
  input  state_t    beta,
  //
  output logic      oval,
  output gamma_t    ogamma,   // gamma_e + alpha
  output state_t    obeta     // beta, aligned with ogamma
);

  // ------------------------------
  // combinational branch sums
  // ------------------------------

  gamma_t gamma_c;

  always_comb begin
    branch_t acc;
    for (int s = 0; s < N_STATES; s++) begin
      for (int h = 0; h < N_HYP; h++) begin
        acc = alpha[s];                       // sign extended
        if (hyp_e'(h) != HYP_00)
          acc = acc + lsys[h] + lapri[h];     // hyp 00 is the reference
        if (trel_parity[s][h][0])
          acc = acc + lpar[0];
        if (trel_parity[s][h][1])
          acc = acc + lpar[1];
        gamma_c[s][h] = acc;
      end
    end
  end

  // ------------------------------
  // output register
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)
      oval <= 1'b0;
    else if (iclkena)
      oval <= ival;
  end

  // payload, no reset
  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      ogamma <= gamma_c;
      obeta  <= beta;     // one cycle later than alpha path would be wrong
    end
  end

  // valid never X once out of reset
  a_oval_known : assert property (
    @(posedge iclk) disable iff (ireset)
    !$isunknown(oval)
  );

endmodule

// ==== rsc2_dec_lapo.sv ====
// a-posteriori LLR max tree

module rsc2_dec_lapo
  import rsc2_dec_pkg::*;
(
  input  logic   iclk,
  input  logic   ireset,
  input  logic   iclkena,
  //
  input  logic   ival,
  input  gamma_t igamma,    // gamma_e + alpha[k]
  input  state_t istate,    // beta[k+1]
  //
  output logic   oval,
  output lapo_t  olapo
);

  // ------------------------------
  // stage valids
  // ------------------------------

  logic [LAPO_LATENCY-1:0] val;   // bit n set -> stage n+1 holds data

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)
      val <= '0;
    else if (iclkena)
      val <= {val[LAPO_LATENCY-2:0], ival};
  end

  assign oval = val[LAPO_LATENCY-1];

  // ------------------------------
  // stage 1: full branch metric
  // ------------------------------

  bm_t bm;

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      for (int s = 0; s < N_STATES; s++) begin
        for (int h = 0; h < N_HYP; h++) begin
          // beta picked at the branch end state
          bm[s][h] <= igamma[s][h] + istate[trel_next_states[s][h]];
        end
      end
    end
  end

  // ------------------------------
  // stages 2..5: max over states
  // ------------------------------

  branch_t lay1 [N_HYP][N_STATES/2];    // pairs
  branch_t lay2 [N_HYP][N_STATES/4];    // quads
  branch_t lay3 [N_HYP][N_STATES/8];    // halves
  branch_t lay4 [N_HYP];                // one per hypothesis

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int h = 0; h < N_HYP; h++) begin
        // layer 1
        if (val[0]) begin
          for (int i = 0; i < N_STATES/2; i++)
            lay1[h][i] <= bm_max(bm[2*i][h], bm[2*i+1][h]);
        end
        // layer 2
        if (val[1]) begin
          for (int i = 0; i < N_STATES/4; i++)
            lay2[h][i] <= bm_max(lay1[h][2*i], lay1[h][2*i+1]);
        end
        // layer 3
        if (val[2]) begin
          for (int i = 0; i < N_STATES/8; i++)
            lay3[h][i] <= bm_max(lay2[h][2*i], lay2[h][2*i+1]);
        end
        // layer 4
        if (val[3])
          lay4[h] <= bm_max(lay3[h][0], lay3[h][1]);
      end
    end
  end

  // ------------------------------
  // stage 6: offset against hyp 00
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && val[4]) begin
      for (int h = 1; h < N_HYP; h++)
        olapo[h] <= lay4[h] - lay4[HYP_00];   // ratio to the all-zero duobit
    end
  end

  // every accepted input leaves exactly LAPO_LATENCY enabled edges later
  a_latency : assert property (
    @(posedge iclk) disable iff (ireset)
    (ival && iclkena) |=> iclkena [-> (LAPO_LATENCY - 1)] ##1 oval
  );

endmodule

// ==== rsc2_dec_lextr.sv ====
// extrinsic LLR and output register

module rsc2_dec_lextr
  import rsc2_dec_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  //
  input  logic     oready,      // downstream accepts
  input  logic     in_take,     // symbol accepted at the input side
  input  hyp_llr_t lsys,
  input  hyp_llr_t lapri,
  input  logic     lapo_val,
  input  lapo_t    lapo,
  //
  output logic     clkena,      // pipeline enable
  output logic     out_valid,
  output extr_t    lextr
);

  // ------------------------------
  // a-priori + systematic delay
  // ------------------------------

  lapo_t apri_sum;
  lapo_t apri_dly [LAPO_LATENCY+1];   // last stage lines up with lapo

  always_comb begin
    for (int h = 1; h < N_HYP; h++)
      apri_sum[h] = lsys[h] + lapri[h];   // widened to BM_W
  end

  always_ff @(posedge iclk) begin
    if (clkena) begin
      if (in_take)
        apri_dly[0] <= apri_sum;
      for (int i = 1; i <= LAPO_LATENCY; i++)
        apri_dly[i] <= apri_dly[i-1];
    end
  end

  // ------------------------------
  // output register and hold
  // ------------------------------

  assign clkena = !(out_valid && !oready);   // stall only when full and not taken

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)
      out_valid <= 1'b0;
    else if (clkena)
      out_valid <= lapo_val;
  end

  always_ff @(posedge iclk) begin
    if (clkena && lapo_val) begin
      for (int h = 1; h < N_HYP; h++)
        lextr[h] <= sat_extr(lapo[h] - apri_dly[LAPO_LATENCY][h]);
    end
  end

  // held result does not move
  a_hold_stable : assert property (
    @(posedge iclk) disable iff (ireset)
    (out_valid && !oready) |=> $stable(lextr)
  );

  // upstream frozen while held, no new lapo shows up
  a_no_lapo_in_hold : assert property (
    @(posedge iclk) disable iff (ireset)
    !clkena |=> !$rose(lapo_val)
  );

endmodule

// ==== rsc2_dec_llr_unit.sv ====
// extrinsic LLR unit top

module rsc2_dec_llr_unit
  import rsc2_dec_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  // input side
  input  logic      in_valid,
  input  hyp_llr_t  lsys,
  input  hyp_llr_t  lapri,
  input  llr_pair_t lpar,
  input  state_t    alpha,
  input  state_t    beta,
  output logic      in_ready,
  // output side
  output logic      out_valid,
  output extr_t     lextr,
  input  logic      out_ready
);

  // ------------------------------
  // internal nets
  // ------------------------------

  logic   clkena;        // one enable for the whole pipe
  logic   in_take;
  logic   gamma_val;
  gamma_t gamma_alpha;
  state_t gamma_beta;    // beta delayed one cycle
  logic   lapo_val;
  lapo_t  lapo;

  assign in_take  = in_valid && clkena;
  assign in_ready = clkena;

  // ------------------------------
  // pipeline
  // ------------------------------

  rsc2_dec_gamma i_gamma (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (clkena),
    .ival    (in_take),
    .lsys    (lsys),
    .lapri   (lapri),
    .lpar    (lpar),
    .alpha   (alpha),
    .beta    (beta),
    .oval    (gamma_val),
    .ogamma  (gamma_alpha),
    .obeta   (gamma_beta)
  );

  rsc2_dec_lapo i_lapo (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (clkena),
    .ival    (gamma_val),
    .igamma  (gamma_alpha),
    .istate  (gamma_beta),
    .oval    (lapo_val),
    .olapo   (lapo)
  );

  // also owns the stall
  rsc2_dec_lextr i_lextr (
    .iclk      (iclk),
    .ireset    (ireset),
    .oready    (out_ready),
    .in_take   (in_take),
    .lsys      (lsys),
    .lapri     (lapri),
    .lapo_val  (lapo_val),
    .lapo      (lapo),
    .clkena    (clkena),
    .out_valid (out_valid),
    .lextr     (lextr)
  );

endmodule

// ==== tb_rsc2_llr_unit.sv ====
// extrinsic LLR unit testbench

module tb_rsc2_llr_unit
  import rsc2_dec_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // run sizes and limits
  // ------------------------------

  localparam int N_UNIFORM   = 8;
  localparam int N_SPIKE     = 16;
  localparam int N_STREAM    = 64;
  localparam int N_BACKPRESS = 64;
  localparam int N_SAT       = 8;
  localparam int N_TOTAL     = N_UNIFORM + N_SPIKE + N_STREAM + N_BACKPRESS + N_SAT;
  localparam int CYCLE_LIMIT = 20 * N_TOTAL + 200;

  localparam int EXT_HI = (1 << (EXTR_W - 1)) - 1;   // +31
  localparam int EXT_LO = -(1 << (EXTR_W - 1));      // -32

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic      iclk = 1'b0;
  logic      ireset;
  logic      in_valid;
  hyp_llr_t  lsys;
  hyp_llr_t  lapri;
  llr_pair_t lpar;
  state_t    alpha;
  state_t    beta;
  logic      in_ready;
  logic      out_valid;
  extr_t     lextr;
  logic      out_ready;

  rsc2_dec_llr_unit i_dut (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .lsys      (lsys),
    .lapri     (lapri),
    .lpar      (lpar),
    .alpha     (alpha),
    .beta      (beta),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .lextr     (lextr),
    .out_ready (out_ready)
  );

  always #4 iclk = ~iclk;   // 8 ns period

  // ------------------------------
  // random source
  // ------------------------------

  logic [15:0] lfsr = 16'd30141;

  // galois form with taps x^16+x^14+x^13+x^11+1
  function automatic logic lfsr_next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 16'hB400;
    return b;
  endfunction

  function automatic int take_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = (v << 1) | int'(lfsr_next_bit());
    return v;
  endfunction

  function automatic int rand_signed(int n);
    int v;
    v = take_bits(n);
    if (v >= (1 << (n - 1)))
      v = v - (1 << n);   // two's complement
    return v;
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic extr_t expect_extr(hyp_llr_t s_llr, hyp_llr_t a_llr, llr_pair_t p_llr,
                                        state_t al, state_t be);
    int    best [N_HYP];
    int    hsum [N_HYP];
    int    m;
    int    v;
    extr_t res;
    hsum[0] = 0;   // hyp 00 carries no symbol term
    for (int h = 1; h < N_HYP; h++)
      hsum[h] = int'(s_llr[h]) + int'(a_llr[h]);
    for (int h = 0; h < N_HYP; h++)
      best[h] = -100000;
    for (int s = 0; s < N_STATES; s++) begin
      for (int h = 0; h < N_HYP; h++) begin
        m = int'(al[s]) + int'(be[trel_next_states[s][h]]) + hsum[h];
        if (trel_parity[s][h][0])
          m = m + int'(p_llr[0]);
        if (trel_parity[s][h][1])
          m = m + int'(p_llr[1]);
        if (m > best[h])
          best[h] = m;
      end
    end
    for (int h = 1; h < N_HYP; h++) begin
      v = best[h] - best[0] - hsum[h];   // a-posteriori minus a-priori and systematic
      if (v > EXT_HI)
        v = EXT_HI;
      if (v < EXT_LO)
        v = EXT_LO;
      res[h] = extr_val_t'(v);
    end
    return res;
  endfunction

  function automatic string extr_str(extr_t v);
    return $sformatf("%0d/%0d/%0d", v[1], v[2], v[3]);
  endfunction

  // ------------------------------
  // scoreboard
  // ------------------------------

  extr_t exp_q [$];
  extr_t exp_head;
  int    pending;
  int    checked;
  int    n_sent;
  int    errors;
  int    cycles;
  logic  bp_mode;       // random out_ready
  logic  uniform_chk;   // outputs must be zero
  logic  sat_chk;       // outputs must sit on a rail

  always @(posedge iclk) begin
    if (!ireset) begin
      if (in_valid && in_ready)
        exp_q.push_back(expect_extr(lsys, lapri, lpar, alpha, beta));
      if (out_valid && out_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        checked++;
      end
    end
    pending  <= exp_q.size();
    exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;   // compared at the next edge
  end

  // downstream ready
  always @(posedge iclk) begin
    if (ireset || !bp_mode)
      out_ready <= 1'b1;
    else
      out_ready <= lfsr_next_bit();
  end

  // watchdog
  always @(posedge iclk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d results still missing", cycles, pending);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_result : assert property (@(posedge iclk) disable iff (ireset)
    (out_valid && out_ready) |-> (lextr == exp_head))
    else begin
      errors++;
      $display("Error: %0t lextr expected %s got %s", $time,
               extr_str($sampled(exp_head)), extr_str($sampled(lextr)));
    end

  a_hold : assert property (@(posedge iclk) disable iff (ireset)
    (out_valid && !out_ready) |=> (out_valid && $stable(lextr)))
    else begin
      errors++;
      $display("held result changed or vanished while out_ready was low at %0t", $time);
    end

  a_no_orphan : assert property (@(posedge iclk) disable iff (ireset)
    out_valid |-> (pending > 0))
    else begin
      errors++;
      $display("output valid at %0t with no accepted symbol outstanding", $time);
    end

  a_reset_state : assert property (@(posedge iclk)
    $fell(ireset) |-> (in_ready && !out_valid))
    else begin
      errors++;
      $display("Error: %0t in_ready/out_valid expected 1/0 got %0d/%0d", $time,
               $sampled(in_ready), $sampled(out_valid));
    end

  a_uniform_zero : assert property (@(posedge iclk) disable iff (ireset)
    (uniform_chk && out_valid && out_ready) |-> (lextr == '0))
    else begin
      errors++;
      $display("Error: %0t lextr expected 0/0/0 got %s", $time, extr_str($sampled(lextr)));
    end

  a_sat_rail : assert property (@(posedge iclk) disable iff (ireset)
    (sat_chk && out_valid && out_ready) |->
      ((lextr[1] == EXT_HI || lextr[1] == EXT_LO) &&
       (lextr[2] == EXT_HI || lextr[2] == EXT_LO) &&
       (lextr[3] == EXT_HI || lextr[3] == EXT_LO)))
    else begin
      errors++;
      $display("Error: %0t lextr expected %0d or %0d per hyp got %s", $time,
               EXT_HI, EXT_LO, extr_str($sampled(lextr)));
    end

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  // holds the symbol until the accepting edge
  task automatic send_symbol(input hyp_llr_t s_llr, input hyp_llr_t a_llr,
                             input llr_pair_t p_llr, input state_t al, input state_t be);
    in_valid <= 1'b1;
    lsys     <= s_llr;
    lapri    <= a_llr;
    lpar     <= p_llr;
    alpha    <= al;
    beta     <= be;
    @(posedge iclk);
    while (!in_ready)
      @(posedge iclk);
    n_sent++;
  endtask

  task automatic random_symbol(output hyp_llr_t s_llr, output hyp_llr_t a_llr,
                               output llr_pair_t p_llr, output state_t al, output state_t be);
    for (int h = 1; h < N_HYP; h++) begin
      s_llr[h] = llr_t'(rand_signed(LLR_W));
      a_llr[h] = llr_t'(rand_signed(LLR_W));
    end
    p_llr[0] = llr_t'(rand_signed(LLR_W));
    p_llr[1] = llr_t'(rand_signed(LLR_W));
    for (int s = 0; s < N_STATES; s++) begin
      al[s] = metric_t'(rand_signed(8));   // keeps the tree clear of wrap
      be[s] = metric_t'(rand_signed(8));
    end
  endtask

  task automatic drain();
    in_valid <= 1'b0;
    do
      @(posedge iclk);
    while (pending != 0);
    @(posedge iclk);
  endtask

  task automatic test_done(input int num, input string name);
    $display("test %0d %s done: %0d sent, %0d checked, %0d errors",
             num, name, n_sent, checked, errors);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    hyp_llr_t  s_llr;
    hyp_llr_t  a_llr;
    llr_pair_t p_llr;
    state_t    al;
    state_t    be;
    metric_t   flat_a;
    metric_t   flat_b;
    int        s0;
    logic      neg;
    ireset      = 1'b1;
    in_valid    = 1'b0;
    lsys        = '0;
    lapri       = '0;
    lpar        = '0;
    alpha       = '0;
    beta        = '0;
    out_ready   = 1'b1;
    bp_mode     = 1'b0;
    uniform_chk = 1'b0;
    sat_chk     = 1'b0;
    repeat (3) @(posedge iclk);
    ireset <= 1'b0;
    // idle with ready already up
    repeat (4) @(posedge iclk);
    test_done(1, "reset");

    // flat metrics and zero parity
    uniform_chk <= 1'b1;
    for (int n = 0; n < N_UNIFORM; n++) begin
      random_symbol(s_llr, a_llr, p_llr, al, be);
      p_llr  = '0;
      flat_a = metric_t'(rand_signed(8));
      flat_b = metric_t'(rand_signed(8));
      al     = {N_STATES{flat_a}};
      be     = {N_STATES{flat_b}};
      send_symbol(s_llr, a_llr, p_llr, al, be);
    end
    drain();
    uniform_chk <= 1'b0;
    test_done(2, "uniform");

    // one hot beta state
    for (int n = 0; n < N_SPIKE; n++) begin
      random_symbol(s_llr, a_llr, p_llr, al, be);
      be[take_bits(4)] = metric_t'(400);
      send_symbol(s_llr, a_llr, p_llr, al, be);
    end
    drain();
    test_done(3, "spike");

    // back to back at full rate
    for (int n = 0; n < N_STREAM; n++) begin
      random_symbol(s_llr, a_llr, p_llr, al, be);
      send_symbol(s_llr, a_llr, p_llr, al, be);
    end
    drain();
    test_done(4, "stream");

    // random stalls plus input bubbles
    bp_mode <= 1'b1;
    for (int n = 0; n < N_BACKPRESS; n++) begin
      if (lfsr_next_bit()) begin
        in_valid <= 1'b0;
        @(posedge iclk);
      end
      random_symbol(s_llr, a_llr, p_llr, al, be);
      send_symbol(s_llr, a_llr, p_llr, al, be);
    end
    drain();
    bp_mode <= 1'b0;
    test_done(5, "backpressure");

    // one strong path whose sign picks the rail
    sat_chk <= 1'b1;
    for (int n = 0; n < N_SAT; n++) begin
      s0  = take_bits(4);
      neg = lfsr_next_bit();
      for (int h = 1; h < N_HYP; h++) begin
        s_llr[h] = lfsr_next_bit() ? llr_t'(15) : llr_t'(-16);
        a_llr[h] = lfsr_next_bit() ? llr_t'(15) : llr_t'(-16);
      end
      p_llr[0] = lfsr_next_bit() ? llr_t'(15) : llr_t'(-16);
      p_llr[1] = lfsr_next_bit() ? llr_t'(15) : llr_t'(-16);
      for (int s = 0; s < N_STATES; s++) begin
        al[s] = (s == s0) ? metric_t'(200) : metric_t'(-200);
        be[s] = metric_t'(-200);
      end
      for (int h = 0; h < N_HYP; h++)
        be[trel_next_states[s0][h]] = ((h == 0) == neg) ? metric_t'(200) : metric_t'(-200);
      send_symbol(s_llr, a_llr, p_llr, al, be);
    end
    drain();
    sat_chk <= 1'b0;
    test_done(6, "saturation");

    if (checked != n_sent) begin
      errors++;
      $display("%0d symbols sent but only %0d results came back", n_sent, checked);
    end
    $display("tests 6, symbols %0d, results checked %0d, errors %0d", n_sent, checked, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
rsc2_dec_pkg.sv
rsc2_dec_gamma.sv
rsc2_dec_lapo.sv
rsc2_dec_lextr.sv
rsc2_dec_llr_unit.sv
tb_rsc2_llr_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_rsc2_llr_unit -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
